// ==== tlb_cfg_pkg.sv ====
`default_nettype none

package tlb_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // sv39 address layout
  ////////////////////////////////////////////////////////////

  localparam int unsigned VLEN         = 39;  // virtual address bits
  localparam int unsigned PAGE_OFFSET  = 12;  // 4K page offset
  localparam int unsigned PT_LEVELS    = 3;
  localparam int unsigned VPN_PART_LEN = 9;   // vpn bits per level
  localparam int unsigned VPN_LEN      = PT_LEVELS * VPN_PART_LEN;

  localparam int unsigned ASID_LEN     = 16;
  localparam int unsigned PPN_LEN      = 44;

  // vectors with a meaning of their own
  typedef logic [VLEN-1:0]         vaddr_t;
  typedef logic [VPN_LEN-1:0]      vpn_t;       // full vpn, vaddr[38:12]
  typedef logic [VPN_PART_LEN-1:0] vpn_part_t;  // one level's slice
  typedef logic [ASID_LEN-1:0]     asid_t;
  typedef logic [PPN_LEN-1:0]      ppn_t;

endpackage

`default_nettype wire

// ==== tlb_entry_pkg.sv ====
`default_nettype none

package tlb_entry_pkg;

  // leaf pte as held in the tlb, rsw and reserved bits not kept
  typedef struct packed {
    tlb_cfg_pkg::ppn_t ppn;
    logic              d;
    logic              a;
    logic              g;  // global mapping, matches any asid
    logic              u;
    logic              x;
    logic              w;
    logic              r;
    logic              v;
  } pte_t;

  // is_page[0] marks a 1G page, is_page[1] a 2M page
  typedef struct packed {
    tlb_cfg_pkg::asid_t                                asid;
    tlb_cfg_pkg::vpn_part_t [tlb_cfg_pkg::PT_LEVELS-1:0] vpn;  // [0] is the 4K level
    logic [tlb_cfg_pkg::PT_LEVELS-2:0]                 is_page;
  } tag_t;

  // walker result in, refill record out to itlb / dtlb
  typedef struct packed {
    logic                              valid;
    tlb_cfg_pkg::vpn_t                 vpn;
    tlb_cfg_pkg::asid_t                asid;
    logic [tlb_cfg_pkg::PT_LEVELS-2:0] is_page;  // same encoding as tag_t
    pte_t                              content;
  } tlb_update_t;

  // context of the lookup in flight
  typedef struct packed {
    tlb_cfg_pkg::asid_t asid;
    tlb_cfg_pkg::vpn_t  vpn;
    logic               is_itlb;  // refill goes back to the itlb
  } lookup_t;

endpackage

`default_nettype wire

// ==== shared_tlb_miss_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module shared_tlb_miss_arb #(
  parameter int unsigned TLB_DEPTH = 16
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   itlb_access_i,
  input  wire logic                   itlb_hit_i,
  input  wire tlb_cfg_pkg::vaddr_t    itlb_vaddr_i,
  input  wire tlb_cfg_pkg::asid_t     itlb_asid_i,
  input  wire logic                   dtlb_access_i,
  input  wire logic                   dtlb_hit_i,
  input  wire tlb_cfg_pkg::vaddr_t    dtlb_vaddr_i,
  input  wire tlb_cfg_pkg::asid_t     dtlb_asid_i,
  output logic                        rd_en_o,
  output logic [$clog2(TLB_DEPTH)-1:0] rd_set_o,
  output tlb_entry_pkg::lookup_t      lookup_o,
  output logic                        itlb_miss_o,
  output logic                        dtlb_miss_o,
  output logic                        access_o,
  output tlb_cfg_pkg::vaddr_t         vaddr_o
);

  import tlb_cfg_pkg::*;

  localparam int unsigned SET_W = $clog2(TLB_DEPTH);

  logic   miss;
  vaddr_t miss_vaddr;
  asid_t  miss_asid;

  // the data side owns the lookup port while it is accessing,
  // an itlb miss only gets through when the dtlb is idle
  assign dtlb_miss_o = dtlb_access_i & ~dtlb_hit_i;
  assign itlb_miss_o = itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;
  assign miss        = itlb_miss_o | dtlb_miss_o;

  assign miss_vaddr = dtlb_miss_o ? dtlb_vaddr_i : itlb_vaddr_i;
  assign miss_asid  = dtlb_miss_o ? dtlb_asid_i : itlb_asid_i;

  // read strobe goes to the arrays in the miss cycle
  assign rd_en_o  = miss;
  assign rd_set_o = miss_vaddr[PAGE_OFFSET +: SET_W];  // low vpn bits

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      access_o <= 1'b0;
    end else begin
      access_o <= miss;  // one lookup in flight
    end
  end

  // lookup context, a newer miss simply overwrites it
  always_ff @(posedge clk_i) begin
    if (miss) begin
      vaddr_o          <= miss_vaddr;
      lookup_o.asid    <= miss_asid;
      lookup_o.vpn     <= miss_vaddr[PAGE_OFFSET +: VPN_LEN];
      lookup_o.is_itlb <= itlb_miss_o;
    end
  end

  // a served miss carries a known address and asid
  a_miss_ctx_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss |-> !$isunknown({miss_vaddr, miss_asid}));

endmodule

`default_nettype wire

// ==== shared_tlb_ways.sv ====
`timescale 1ns/1ps
`default_nettype none

module shared_tlb_ways #(
  parameter int unsigned TLB_DEPTH = 16,
  parameter int unsigned TLB_WAYS  = 2
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         flush_i,
  input  wire logic                         rd_en_i,
  input  wire logic [$clog2(TLB_DEPTH)-1:0] rd_set_i,
  input  wire tlb_entry_pkg::tlb_update_t   update_i,
  input  wire logic [TLB_WAYS-1:0]          victim_oh_i,
  output tlb_entry_pkg::tag_t [TLB_WAYS-1:0] tag_o,
  output tlb_entry_pkg::pte_t [TLB_WAYS-1:0] pte_o,
  output logic [TLB_WAYS-1:0]               valid_o,
  output logic [TLB_WAYS-1:0]               way_valid_o
);

  import tlb_entry_pkg::*;

  localparam int unsigned SET_W = $clog2(TLB_DEPTH);

  tag_t tag_mem [TLB_WAYS][TLB_DEPTH];
  pte_t pte_mem [TLB_WAYS][TLB_DEPTH];

  logic [TLB_DEPTH-1:0][TLB_WAYS-1:0] valid_q;  // set x way

  logic [TLB_WAYS-1:0] wr_en;
  logic [SET_W-1:0]    wr_set;
  logic [SET_W-1:0]    addr;   // one port per way, shared address
  tag_t                wr_tag;

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  assign wr_set = update_i.vpn[SET_W-1:0];
  assign wr_en  = (update_i.valid && !flush_i) ? victim_oh_i : '0;
  assign addr   = (|wr_en) ? wr_set : rd_set_i;  // write wins the port

  assign wr_tag.asid    = update_i.asid;
  assign wr_tag.vpn     = update_i.vpn;
  assign wr_tag.is_page = update_i.is_page;

  ////////////////////////////////////////////////////////////
  // tag and pte arrays, synchronous read
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < TLB_WAYS; w++) begin
      if (wr_en[w]) begin
        tag_mem[w][addr] <= wr_tag;
        pte_mem[w][addr] <= update_i.content;
      end else if (rd_en_i) begin
        tag_o[w] <= tag_mem[w][addr];
        pte_o[w] <= pte_mem[w][addr];
      end
    end
  end

  // valid matrix, flush clears everything
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      valid_o <= '0;
    end else begin
      if (flush_i) begin
        valid_q <= '0;
      end else if (update_i.valid) begin
        valid_q[wr_set] <= valid_q[wr_set] | victim_oh_i;
      end
      if (rd_en_i) begin
        valid_o <= valid_q[rd_set_i];  // lines up with the array read
      end
    end
  end

  assign way_valid_o = valid_q[wr_set];  // to the victim picker

  a_victim_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    update_i.valid |-> $onehot(victim_oh_i));

endmodule

`default_nettype wire

// ==== shared_tlb_hit_cmp.sv ====
`timescale 1ns/1ps
`default_nettype none

module shared_tlb_hit_cmp #(
  parameter int unsigned TLB_WAYS = 2
) (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire tlb_entry_pkg::tag_t [TLB_WAYS-1:0] tag_i,
  input  wire tlb_entry_pkg::pte_t [TLB_WAYS-1:0] pte_i,
  input  wire logic [TLB_WAYS-1:0]           valid_i,
  input  wire tlb_entry_pkg::lookup_t        lookup_i,
  input  wire logic                          req_pending_i,
  output logic                               hit_o,
  output tlb_entry_pkg::tlb_update_t         itlb_update_o,
  output tlb_entry_pkg::tlb_update_t         dtlb_update_o
);

  import tlb_cfg_pkg::*;
  import tlb_entry_pkg::*;

  vpn_part_t [PT_LEVELS-1:0]          req_vpn;
  logic [TLB_WAYS-1:0][PT_LEVELS-1:0] vpn_match;
  logic [TLB_WAYS-1:0][PT_LEVELS-1:0] page_match;
  logic [TLB_WAYS-1:0][PT_LEVELS-1:0] level_match;
  logic [TLB_WAYS-1:0]                asid_match;
  logic [TLB_WAYS-1:0]                way_hit;
  tlb_update_t                        refill;

  assign req_vpn = lookup_i.vpn;

  for (genvar w = 0; w < TLB_WAYS; w++) begin : gen_way
    for (genvar l = 0; l < PT_LEVELS; l++) begin : gen_level
      assign vpn_match[w][l] = (req_vpn[l] == tag_i[w].vpn[l]);
      if (l == 0) begin : gen_base
        assign page_match[w][l] = 1'b1;  // 4K, all levels compared
      end else begin : gen_super
        // level 2 -> is_page[0] (1G), level 1 -> is_page[1] (2M)
        assign page_match[w][l] = tag_i[w].is_page[PT_LEVELS-1-l];
      end
      // vpn equal from the top down to this level
      assign level_match[w][l] = (&vpn_match[w][PT_LEVELS-1:l]) & page_match[w][l];
    end

    assign asid_match[w] = (tag_i[w].asid == lookup_i.asid) || pte_i[w].g;
    assign way_hit[w]    = req_pending_i & valid_i[w] & asid_match[w]
                         & (|level_match[w]);
  end

  ////////////////////////////////////////////////////////////
  // refill record
  ////////////////////////////////////////////////////////////

  always_comb begin
    refill = '0;
    for (int w = 0; w < TLB_WAYS; w++) begin
      if (way_hit[w]) begin
        refill.valid   = 1'b1;
        refill.vpn     = lookup_i.vpn;   // requested vpn, not the stored one
        refill.asid    = lookup_i.asid;
        refill.is_page = tag_i[w].is_page;
        refill.content = pte_i[w];
      end
    end
  end

  assign hit_o         = |way_hit;
  assign itlb_update_o = lookup_i.is_itlb ? refill : '0;
  assign dtlb_update_o = lookup_i.is_itlb ? '0 : refill;

  // installs never leave two matching ways in a set
  a_one_way_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(way_hit));

endmodule

`default_nettype wire

// ==== shared_tlb_repl.sv ====
`timescale 1ns/1ps
`default_nettype none

module shared_tlb_repl #(
  parameter int unsigned TLB_WAYS = 2
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                update_valid_i,
  input  wire logic [TLB_WAYS-1:0] way_valid_i,
  output logic [TLB_WAYS-1:0]      victim_oh_o
);

  localparam int unsigned WAY_W     = $clog2(TLB_WAYS);
  localparam logic [7:0]  LFSR_SEED = 8'hA5;  // any nonzero value

  logic [7:0]          lfsr_q;
  logic                lfsr_fb;
  logic                all_valid;
  logic                lfsr_en;
  logic [TLB_WAYS-1:0] inv_oh;   // lowest invalid way
  logic [TLB_WAYS-1:0] rnd_oh;   // lfsr pick

  assign all_valid = &way_valid_i;

  // lowest zero bit, comes out all zero when the set is full
  assign inv_oh = ~way_valid_i & (way_valid_i + TLB_WAYS'(1));

  always_comb begin
    rnd_oh = '0;
    rnd_oh[lfsr_q[WAY_W-1:0]] = 1'b1;
  end

  assign victim_oh_o = update_valid_i ? (all_valid ? rnd_oh : inv_oh) : '0;

  ////////////////////////////////////////////////////////////
  // 8-bit fibonacci lfsr, x^8 + x^6 + x^5 + x^4 + 1
  ////////////////////////////////////////////////////////////

  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
  assign lfsr_en = update_valid_i & all_valid;  // only on an eviction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LFSR_SEED;
    end else if (lfsr_en) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
    end
  end

endmodule

`default_nettype wire

// ==== shared_tlb.sv ====
`timescale 1ns/1ps
`default_nettype none

module shared_tlb #(
  parameter int unsigned TLB_DEPTH = 16,
  parameter int unsigned TLB_WAYS  = 2
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      flush_i,

  input  wire logic                      itlb_access_i,
  input  wire logic                      itlb_hit_i,
  input  wire tlb_cfg_pkg::vaddr_t       itlb_vaddr_i,
  input  wire tlb_cfg_pkg::asid_t        itlb_asid_i,

  input  wire logic                      dtlb_access_i,
  input  wire logic                      dtlb_hit_i,
  input  wire tlb_cfg_pkg::vaddr_t       dtlb_vaddr_i,
  input  wire tlb_cfg_pkg::asid_t        dtlb_asid_i,

  input  wire tlb_entry_pkg::tlb_update_t shared_tlb_update_i,  // from the page walker

  output tlb_entry_pkg::tlb_update_t     itlb_update_o,
  output tlb_entry_pkg::tlb_update_t     dtlb_update_o,
  output logic                           itlb_miss_o,
  output logic                           dtlb_miss_o,
  output logic                           shared_tlb_access_o,
  output logic                           shared_tlb_hit_o,
  output tlb_cfg_pkg::vaddr_t            shared_tlb_vaddr_o
);

  import tlb_entry_pkg::*;

  localparam int unsigned SET_W = $clog2(TLB_DEPTH);

  logic                rd_en;
  logic [SET_W-1:0]    rd_set;
  lookup_t             lookup;
  tag_t [TLB_WAYS-1:0] way_tag;
  pte_t [TLB_WAYS-1:0] way_pte;
  logic [TLB_WAYS-1:0] rd_valid;       // valid bits of the looked-up set
  logic [TLB_WAYS-1:0] upd_way_valid;  // valid bits of the update set
  logic [TLB_WAYS-1:0] victim_oh;

  shared_tlb_miss_arb #(
    .TLB_DEPTH(TLB_DEPTH)
  ) u_miss_arb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .itlb_access_i(itlb_access_i),
    .itlb_hit_i   (itlb_hit_i),
    .itlb_vaddr_i (itlb_vaddr_i),
    .itlb_asid_i  (itlb_asid_i),
    .dtlb_access_i(dtlb_access_i),
    .dtlb_hit_i   (dtlb_hit_i),
    .dtlb_vaddr_i (dtlb_vaddr_i),
    .dtlb_asid_i  (dtlb_asid_i),
    .rd_en_o      (rd_en),
    .rd_set_o     (rd_set),
    .lookup_o     (lookup),
    .itlb_miss_o  (itlb_miss_o),
    .dtlb_miss_o  (dtlb_miss_o),
    .access_o     (shared_tlb_access_o),
    .vaddr_o      (shared_tlb_vaddr_o)
  );

  shared_tlb_ways #(
    .TLB_DEPTH(TLB_DEPTH),
    .TLB_WAYS (TLB_WAYS)
  ) u_ways (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .rd_en_i    (rd_en),
    .rd_set_i   (rd_set),
    .update_i   (shared_tlb_update_i),
    .victim_oh_i(victim_oh),
    .tag_o      (way_tag),
    .pte_o      (way_pte),
    .valid_o    (rd_valid),
    .way_valid_o(upd_way_valid)
  );

  shared_tlb_hit_cmp #(
    .TLB_WAYS(TLB_WAYS)
  ) u_hit_cmp (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .tag_i        (way_tag),
    .pte_i        (way_pte),
    .valid_i      (rd_valid),
    .lookup_i     (lookup),
    .req_pending_i(shared_tlb_access_o),
    .hit_o        (shared_tlb_hit_o),
    .itlb_update_o(itlb_update_o),
    .dtlb_update_o(dtlb_update_o)
  );

  shared_tlb_repl #(
    .TLB_WAYS(TLB_WAYS)
  ) u_repl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .update_valid_i(shared_tlb_update_i.valid),
    .way_valid_i   (upd_way_valid),
    .victim_oh_o   (victim_oh)
  );

endmodule

`default_nettype wire

// ==== tb_shared_tlb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_shared_tlb;

  import tlb_cfg_pkg::*;
  import tlb_entry_pkg::*;

  localparam int unsigned TLB_DEPTH   = 16;
  localparam int unsigned TLB_WAYS    = 2;
  localparam int unsigned SET_W       = $clog2(TLB_DEPTH);
  localparam int unsigned WATCHDOG_NS = 2000;  // roughly 10x the directed sequence
  localparam asid_t       ASID_A      = 16'h0011;
  localparam asid_t       ASID_B      = 16'h0022;

  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  logic        itlb_access_i;
  logic        itlb_hit_i;
  vaddr_t      itlb_vaddr_i;
  asid_t       itlb_asid_i;
  logic        dtlb_access_i;
  logic        dtlb_hit_i;
  vaddr_t      dtlb_vaddr_i;
  asid_t       dtlb_asid_i;
  tlb_update_t shared_tlb_update_i;
  tlb_update_t itlb_update_o;
  tlb_update_t dtlb_update_o;
  logic        itlb_miss_o;
  logic        dtlb_miss_o;
  logic        shared_tlb_access_o;
  logic        shared_tlb_hit_o;
  vaddr_t      shared_tlb_vaddr_o;

  integer      seed;
  tlb_update_t e_4k;
  tlb_update_t e_glob;
  tlb_update_t e_2m;
  tlb_update_t e_1g;
  tlb_update_t e_a;
  tlb_update_t e_b;

  shared_tlb #(
    .TLB_DEPTH(TLB_DEPTH),
    .TLB_WAYS (TLB_WAYS)
  ) u_dut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .itlb_access_i      (itlb_access_i),
    .itlb_hit_i         (itlb_hit_i),
    .itlb_vaddr_i       (itlb_vaddr_i),
    .itlb_asid_i        (itlb_asid_i),
    .dtlb_access_i      (dtlb_access_i),
    .dtlb_hit_i         (dtlb_hit_i),
    .dtlb_vaddr_i       (dtlb_vaddr_i),
    .dtlb_asid_i        (dtlb_asid_i),
    .shared_tlb_update_i(shared_tlb_update_i),
    .itlb_update_o      (itlb_update_o),
    .dtlb_update_o      (dtlb_update_o),
    .itlb_miss_o        (itlb_miss_o),
    .dtlb_miss_o        (dtlb_miss_o),
    .shared_tlb_access_o(shared_tlb_access_o),
    .shared_tlb_hit_o   (shared_tlb_hit_o),
    .shared_tlb_vaddr_o (shared_tlb_vaddr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    abort_sim();
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_sim();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_update(input tlb_update_t act, input tlb_update_t exp, input string what);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, act, exp);
      abort_sim();
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, act, exp);
      abort_sim();
    end
  endtask

  task automatic check_vaddr(input vaddr_t act, input vaddr_t exp, input string what);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, act, exp);
      abort_sim();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // random vpn forced into one set
  function automatic vpn_t pick_vpn(input logic [SET_W-1:0] set);
    vpn_t v;
    v = vpn_t'($unsigned($random(seed)));
    v[SET_W-1:0] = set;
    return v;
  endfunction

  function automatic vaddr_t va_of(input vpn_t vpn);
    return {vpn, PAGE_OFFSET'($unsigned($random(seed)))};  // random page offset
  endfunction

  function automatic tlb_update_t new_entry(input vpn_t vpn, input asid_t asid,
                                            input logic [1:0] is_page, input logic g);
    tlb_update_t e;
    e = '0;
    e.valid       = 1'b1;
    e.vpn         = vpn;
    e.asid        = asid;
    e.is_page     = is_page;
    e.content.ppn = ppn_t'({$random(seed), $random(seed)});
    e.content.d   = 1'b1;
    e.content.a   = 1'b1;
    e.content.g   = g;
    e.content.x   = 1'b1;
    e.content.r   = 1'b1;
    e.content.v   = 1'b1;
    return e;
  endfunction

  // refill carries the requested vpn and asid with the stored page and pte
  function automatic tlb_update_t expected_refill(input tlb_update_t entry, input vpn_t vpn,
                                                  input asid_t asid);
    tlb_update_t r;
    r = entry;
    r.vpn  = vpn;
    r.asid = asid;
    return r;
  endfunction

  task automatic install(input tlb_update_t entry);
    @(posedge clk_i);
    shared_tlb_update_i <= entry;
    @(posedge clk_i);
    shared_tlb_update_i <= '0;
  endtask

  // miss in cycle t, returns mid-cycle t+1 with access_o checked
  task automatic issue_miss(input logic use_itlb, input logic use_dtlb, input vaddr_t ivaddr,
                            input vaddr_t dvaddr, input asid_t asid);
    logic exp_imiss;
    exp_imiss = use_itlb & ~use_dtlb;  // dtlb owns the port when accessing
    @(posedge clk_i);
    itlb_access_i <= use_itlb;
    itlb_vaddr_i  <= ivaddr;
    itlb_asid_i   <= use_dtlb ? ~asid : asid;  // losing or idle side gets another asid
    dtlb_access_i <= use_dtlb;
    dtlb_vaddr_i  <= dvaddr;
    dtlb_asid_i   <= use_dtlb ? asid : ~asid;
    @(negedge clk_i);
    check_bit(itlb_miss_o, exp_imiss, "itlb_miss_o");
    check_bit(dtlb_miss_o, use_dtlb, "dtlb_miss_o");
    @(posedge clk_i);
    itlb_access_i <= 1'b0;
    dtlb_access_i <= 1'b0;
    @(negedge clk_i);
    check_bit(shared_tlb_access_o, 1'b1, "shared_tlb_access_o");
    check_vaddr(shared_tlb_vaddr_o, use_dtlb ? dvaddr : ivaddr, "shared_tlb_vaddr_o");
  endtask

  task automatic expect_result(input logic exp_hit, input logic to_itlb,
                               input tlb_update_t exp, input string what);
    check_bit(shared_tlb_hit_o, exp_hit, {what, " hit"});
    if (exp_hit && to_itlb) begin
      check_update(itlb_update_o, exp, {what, " itlb refill"});
      check_bit(dtlb_update_o.valid, 1'b0, {what, " dtlb valid"});
    end else if (exp_hit) begin
      check_update(dtlb_update_o, exp, {what, " dtlb refill"});
      check_bit(itlb_update_o.valid, 1'b0, {what, " itlb valid"});
    end else begin
      check_bit(itlb_update_o.valid, 1'b0, {what, " itlb valid"});
      check_bit(dtlb_update_o.valid, 1'b0, {what, " dtlb valid"});
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_cold_miss();
    vaddr_t va;
    va = va_of(pick_vpn(SET_W'(0)));
    issue_miss(1'b1, 1'b0, va, '0, ASID_A);
    expect_result(1'b0, 1'b1, '0, "cold miss");
  endtask

  task automatic test_install_hit();
    e_4k = new_entry(pick_vpn(SET_W'(1)), ASID_A, 2'b00, 1'b0);
    install(e_4k);
    issue_miss(1'b1, 1'b0, va_of(e_4k.vpn), '0, ASID_A);
    expect_result(1'b1, 1'b1, expected_refill(e_4k, e_4k.vpn, ASID_A), "4K itlb");
    issue_miss(1'b0, 1'b1, '0, va_of(e_4k.vpn), ASID_A);
    expect_result(1'b1, 1'b0, expected_refill(e_4k, e_4k.vpn, ASID_A), "4K dtlb");
  endtask

  task automatic test_asid_global();
    issue_miss(1'b1, 1'b0, va_of(e_4k.vpn), '0, ASID_B);
    expect_result(1'b0, 1'b1, '0, "other asid");
    e_glob = new_entry(pick_vpn(SET_W'(2)), ASID_A, 2'b00, 1'b1);
    install(e_glob);
    issue_miss(1'b0, 1'b1, '0, va_of(e_glob.vpn), ASID_B);
    expect_result(1'b1, 1'b0, expected_refill(e_glob, e_glob.vpn, ASID_B), "global");
  endtask

  task automatic test_superpages();
    vpn_t r;
    vpn_t v;
    e_2m = new_entry(pick_vpn(SET_W'(3)), ASID_A, 2'b10, 1'b0);  // is_page[1] = 2M
    install(e_2m);
    r = pick_vpn(SET_W'(3));
    v = {e_2m.vpn[26:9], r[8:0]};  // new vpn[0], same set
    issue_miss(1'b1, 1'b0, va_of(v), '0, ASID_A);
    expect_result(1'b1, 1'b1, expected_refill(e_2m, v, ASID_A), "2M page");
    v = v ^ (vpn_t'(1) << 9);  // vpn[1] differs
    issue_miss(1'b1, 1'b0, va_of(v), '0, ASID_A);
    expect_result(1'b0, 1'b1, '0, "2M page other vpn[1]");
    e_1g = new_entry(pick_vpn(SET_W'(4)), ASID_A, 2'b01, 1'b0);  // is_page[0] = 1G
    install(e_1g);
    r = pick_vpn(SET_W'(4));
    v = {e_1g.vpn[26:18], r[17:0]};
    issue_miss(1'b0, 1'b1, '0, va_of(v), ASID_A);
    expect_result(1'b1, 1'b0, expected_refill(e_1g, v, ASID_A), "1G page");
  endtask

  task automatic test_arbitration_ways();
    issue_miss(1'b1, 1'b1, va_of(e_glob.vpn), va_of(e_4k.vpn), ASID_A);
    expect_result(1'b1, 1'b0, expected_refill(e_4k, e_4k.vpn, ASID_A), "dtlb wins");
    e_a = new_entry(pick_vpn(SET_W'(5)), ASID_A, 2'b00, 1'b0);
    e_b = new_entry(pick_vpn(SET_W'(5)), ASID_A, 2'b00, 1'b0);  // same set, second way
    install(e_a);
    install(e_b);
    issue_miss(1'b1, 1'b0, va_of(e_a.vpn), '0, ASID_A);
    expect_result(1'b1, 1'b1, expected_refill(e_a, e_a.vpn, ASID_A), "way a");
    issue_miss(1'b0, 1'b1, '0, va_of(e_b.vpn), ASID_A);
    expect_result(1'b1, 1'b0, expected_refill(e_b, e_b.vpn, ASID_A), "way b");
  endtask

  task automatic test_flush();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    issue_miss(1'b1, 1'b0, va_of(e_4k.vpn), '0, ASID_A);
    expect_result(1'b0, 1'b1, '0, "flushed 4K");
    issue_miss(1'b0, 1'b1, '0, va_of(e_glob.vpn), ASID_B);
    expect_result(1'b0, 1'b0, '0, "flushed global");
    issue_miss(1'b1, 1'b0, va_of(e_b.vpn), '0, ASID_A);
    expect_result(1'b0, 1'b1, '0, "flushed way b");
  endtask

  initial begin
    seed                = 32'h7a69;
    rst_ni              = 1'b0;
    flush_i             = 1'b0;
    itlb_access_i       = 1'b0;
    itlb_hit_i          = 1'b0;  // first-level tlbs always miss here
    itlb_vaddr_i        = '0;
    itlb_asid_i         = '0;
    dtlb_access_i       = 1'b0;
    dtlb_hit_i          = 1'b0;
    dtlb_vaddr_i        = '0;
    dtlb_asid_i         = '0;
    shared_tlb_update_i = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_cold_miss();
    test_install_hit();
    test_asid_global();
    test_superpages();
    test_arbitration_ways();
    test_flush();

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
tlb_cfg_pkg.sv
tlb_entry_pkg.sv
shared_tlb_miss_arb.sv
shared_tlb_ways.sv
shared_tlb_hit_cmp.sv
shared_tlb_repl.sv
shared_tlb.sv
tb_shared_tlb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the shared TLB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_shared_tlb \
  --Mdir obj_dir -o tb_shared_tlb

status=0
./obj_dir/tb_shared_tlb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "tests failed" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation PASSED"
exit 0
